/* Bender.yml */
package:
  name: cpu_dispatcher

sources:
  - include_dirs:
      - include
    files:
      - hdl/disp_pkg.sv
      - hdl/cpu_slot_sched.sv
      - hdl/mem_bridge.sv
      - hdl/dispatch_ctl.sv
      - hdl/cpu_dispatcher.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cpu_dispatcher_chk.sv
      - tests/cpu_dispatcher_tb.sv

/* hdl/cpu_dispatcher.sv */
`timescale 1ns/1ps

module cpu_dispatcher (
  input  logic                clk,
  input  logic                ext_rst_e,

  // cpu bus control
  input  logic                bus_busy,
  input  logic                dispatcher_q,
  input  logic                cpu_e,
  input  disp_pkg::cpu_msg_t  cpu_msg,
  output logic                cpu_q,
  output disp_pkg::cpu_idx_t  cpu_index,

  // cpu memory requests
  input  logic                read_q,
  input  logic                write_q,
  input  disp_pkg::addr_t     cpu_addr,
  input  disp_pkg::data_t     cpu_wdata,
  output logic                read_dn,
  output logic                write_dn,
  output disp_pkg::data_t     cpu_rdata,

  // external memory port
  output logic                ext_read_q,
  output logic                ext_write_q,
  output disp_pkg::addr_t     ext_mem_addr,
  output disp_pkg::data_t     ext_mem_wdata,
  input  disp_pkg::data_t     ext_mem_rdata,
  input  logic                ext_read_dn,
  input  logic                ext_write_dn
);

  // controller to scheduler
  logic sched_advance;
  logic msg_strobe;
  // controller and bridge handshake
  logic req_accept;
  logic bridge_busy;

  dispatch_ctl u_ctl (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .bus_busy      (bus_busy),
    .dispatcher_q  (dispatcher_q),
    .cpu_e         (cpu_e),
    .bridge_busy   (bridge_busy),
    .cpu_q         (cpu_q),
    .sched_advance (sched_advance),
    .msg_strobe    (msg_strobe),
    .req_accept    (req_accept)
  );

  cpu_slot_sched u_sched (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .sched_advance (sched_advance),
    .msg_strobe    (msg_strobe),
    .cpu_msg       (cpu_msg),
    .cpu_index     (cpu_index)
  );

  mem_bridge u_bridge (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .req_accept    (req_accept),
    .read_q        (read_q),
    .write_q       (write_q),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .ext_mem_rdata (ext_mem_rdata),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .bridge_busy   (bridge_busy),
    .ext_read_q    (ext_read_q),
    .ext_write_q   (ext_write_q),
    .ext_mem_addr  (ext_mem_addr),
    .ext_mem_wdata (ext_mem_wdata),
    .read_dn       (read_dn),
    .write_dn      (write_dn),
    .cpu_rdata     (cpu_rdata)
  );

endmodule

/* hdl/cpu_slot_sched.sv */
`timescale 1ns/1ps

`include "disp_cfg.svh"

module cpu_slot_sched (
  input  logic                clk,
  input  logic                ext_rst_e,
  input  logic                sched_advance,
  input  logic                msg_strobe,
  input  disp_pkg::cpu_msg_t  cpu_msg,
  output disp_pkg::cpu_idx_t  cpu_index
);

  import disp_pkg::*;

  // width of the cpu number field below the active flag
  localparam int NUM_W = `DISP_ACTIVE_BIT;
  // counts run from 0 to DISP_CPU_QTY inclusive
  localparam int CNT_W = $clog2(`DISP_CPU_QTY + 1);

  logic [CNT_W-1:0] active_cnt;
  logic [CNT_W-1:0] idle_cnt;
  logic [NUM_W-1:0] cpu_num;
  // last grant went to the idle slot
  logic             idle_granted;

  // next cpu number with one spare bit for the wrap compare
  logic [NUM_W:0]   num_inc;
  logic [NUM_W-1:0] num_next;
  cpu_idx_t         active_idx;

  always_comb begin
    num_inc = {1'b0, cpu_num} + 1'b1;
    // wrap once past the last active cpu
    if (num_inc >= (NUM_W+1)'(active_cnt)) begin
      num_next = '0;
    end else begin
      num_next = num_inc[NUM_W-1:0];
    end
  end

  always_comb begin
    active_idx = '0;
    active_idx[`DISP_ACTIVE_BIT] = 1'b1;
    active_idx[NUM_W-1:0] = num_next;
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      active_cnt   <= '0;
      idle_cnt     <= CNT_W'(`DISP_CPU_QTY);
      cpu_num      <= '0;
      idle_granted <= 1'b0;
      cpu_index    <= '0;
    end else if (sched_advance) begin
      if (idle_cnt != '0 && !idle_granted) begin
        // give an idle cpu the chance to start
        cpu_index    <= '0;
        idle_granted <= 1'b1;
      end else begin
        // round robin over the active cpus
        cpu_num      <= num_next;
        cpu_index    <= active_idx;
        idle_granted <= 1'b0;
      end
    end else if (msg_strobe) begin
      case (cpu_msg)
        MSG_START: begin
          // idle cpu joins the active set
          if (idle_cnt != '0) begin
            idle_cnt     <= idle_cnt - 1'b1;
            active_cnt   <= active_cnt + 1'b1;
            cpu_num      <= cpu_num + 1'b1;
            idle_granted <= 1'b0;
          end
        end
        MSG_END: begin
          // active cpu goes back to idle
          if (active_cnt != '0) begin
            active_cnt <= active_cnt - 1'b1;
            idle_cnt   <= idle_cnt + 1'b1;
          end
        end
        default: begin
          // MSG_NONE and unknown codes leave counts alone
        end
      endcase
    end
  end

endmodule

/* hdl/disp_pkg.sv */
`include "disp_cfg.svh"

package disp_pkg;

  // memory side payloads
  typedef logic [`DISP_ADDR_W-1:0] addr_t;
  typedef logic [`DISP_DATA_W-1:0] data_t;

  // slot index driven with cpu_q
  // all zeros is the idle slot
  typedef logic [`DISP_IDX_W-1:0] cpu_idx_t;

  // messages a cpu sends with cpu_e
  typedef enum logic [7:0] {
    MSG_NONE  = 8'h00,
    MSG_START = 8'h01,
    MSG_END   = 8'h02
  } cpu_msg_t;

  // dispatcher phases
  typedef enum logic [1:0] {
    CTL_CPU_LOOP = 2'd0,
    CTL_CPU_CMD  = 2'd1,
    CTL_MEM_WORK = 2'd2
  } ctl_state_t;

endpackage

/* hdl/dispatch_ctl.sv */
`timescale 1ns/1ps

module dispatch_ctl (
  input  logic clk,
  input  logic ext_rst_e,
  input  logic bus_busy,
  input  logic dispatcher_q,
  input  logic cpu_e,
  input  logic bridge_busy,
  output logic cpu_q,
  output logic sched_advance,
  output logic msg_strobe,
  output logic req_accept
);

  import disp_pkg::*;

  ctl_state_t state;
  ctl_state_t state_nxt;

  // grant a slot as soon as the bus is free in the loop phase
  assign sched_advance = (state == CTL_CPU_LOOP) && !bus_busy;

  // cpu may post a memory request for the whole command phase
  assign req_accept = (state == CTL_CPU_CMD);

  // message from the cpu goes straight to the scheduler
  assign msg_strobe = (state == CTL_CPU_CMD) && cpu_e;

  always_comb begin
    state_nxt = state;
    case (state)
      CTL_CPU_LOOP: begin
        // bus_busy high keeps us here
        if (!bus_busy) begin
          state_nxt = CTL_CPU_CMD;
        end
      end
      CTL_CPU_CMD: begin
        // wait for the cpu to report back
        if (cpu_e) begin
          if (dispatcher_q) begin
            state_nxt = CTL_CPU_LOOP;
          end else begin
            state_nxt = CTL_MEM_WORK;
          end
        end
      end
      CTL_MEM_WORK: begin
        // leave only once memory traffic is finished
        if (!bridge_busy && dispatcher_q) begin
          state_nxt = CTL_CPU_LOOP;
        end
      end
      default: begin
        state_nxt = CTL_CPU_LOOP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state <= CTL_CPU_LOOP;
      cpu_q <= 1'b0;
    end else begin
      state <= state_nxt;
      // lines up with the new cpu_index from the scheduler
      cpu_q <= sched_advance;
    end
  end

endmodule

/* hdl/mem_bridge.sv */
`timescale 1ns/1ps

module mem_bridge (
  input  logic             clk,
  input  logic             ext_rst_e,
  input  logic             req_accept,
  input  logic             read_q,
  input  logic             write_q,
  input  disp_pkg::addr_t  cpu_addr,
  input  disp_pkg::data_t  cpu_wdata,
  input  disp_pkg::data_t  ext_mem_rdata,
  input  logic             ext_read_dn,
  input  logic             ext_write_dn,
  output logic             bridge_busy,
  output logic             ext_read_q,
  output logic             ext_write_q,
  output disp_pkg::addr_t  ext_mem_addr,
  output disp_pkg::data_t  ext_mem_wdata,
  output logic             read_dn,
  output logic             write_dn,
  output disp_pkg::data_t  cpu_rdata
);

  import disp_pkg::*;

  // new request only taken in the command phase with nothing pending
  logic take_req;
  // completions of the pending request
  logic rd_done;
  logic wr_done;

  // a pending request is exactly a raised ext strobe
  assign bridge_busy = ext_read_q | ext_write_q;

  assign take_req = req_accept && !bridge_busy;
  assign rd_done  = ext_read_q && ext_read_dn;
  assign wr_done  = ext_write_q && ext_write_dn;

  // strobes and done pulses
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      ext_read_q  <= 1'b0;
      ext_write_q <= 1'b0;
      read_dn     <= 1'b0;
      write_dn    <= 1'b0;
    end else begin
      // done pulses last one cycle
      read_dn  <= 1'b0;
      write_dn <= 1'b0;

      if (take_req) begin
        // read wins when both are requested
        if (read_q) begin
          ext_read_q <= 1'b1;
        end else if (write_q) begin
          ext_write_q <= 1'b1;
        end
      end

      // strobe held until memory answers, however slow
      if (rd_done) begin
        ext_read_q <= 1'b0;
        read_dn    <= 1'b1;
      end
      if (wr_done) begin
        ext_write_q <= 1'b0;
        write_dn    <= 1'b1;
      end
      // done inputs without a pending request are dropped
    end
  end

  // request payload, held stable while the strobe is up
  always_ff @(posedge clk) begin
    if (take_req && (read_q || write_q)) begin
      ext_mem_addr <= cpu_addr;
    end
    if (take_req && !read_q && write_q) begin
      ext_mem_wdata <= cpu_wdata;
    end
  end

  // read data back to the cpu, kept after read_dn
  always_ff @(posedge clk) begin
    if (rd_done) begin
      cpu_rdata <= ext_mem_rdata;
    end
  end

endmodule

/* include/disp_cfg.svh */
`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// memory bus widths
`define DISP_ADDR_W 32
`define DISP_DATA_W 32

// number of cpu slots handed out on the shared bus
`define DISP_CPU_QTY 4

// slot index as seen on cpu_index
`define DISP_IDX_W 8

// flag bit inside the index marking an active cpu
// low bits below it carry the cpu number
`define DISP_ACTIVE_BIT 7

`endif

/* tb.f */
+incdir+include
hdl/disp_pkg.sv
hdl/cpu_slot_sched.sv
hdl/mem_bridge.sv
hdl/dispatch_ctl.sv
hdl/cpu_dispatcher.sv
tests/cpu_dispatcher_chk.sv
tests/cpu_dispatcher_tb.sv

/* tests/cpu_dispatcher_chk.sv */
`timescale 1ns/1ps

module cpu_dispatcher_chk (
  input logic clk,
  input logic ext_rst_e,
  input logic cpu_q,
  input logic ext_read_q,
  input logic ext_write_q,
  input logic ext_read_dn,
  input logic ext_write_dn,
  input logic read_dn,
  input logic write_dn
);

  // failed assertions so far
  int fail_cnt = 0;

  // a grant is a single cycle pulse
  a_grant_pulse: assert property (
    @(posedge clk) disable iff (ext_rst_e) cpu_q |=> !cpu_q
  ) else begin
    $error("cpu_q high two cycles in a row");
    fail_cnt++;
  end

  // only one request pending on the external port
  a_one_strobe: assert property (
    @(posedge clk) disable iff (ext_rst_e) !(ext_read_q && ext_write_q)
  ) else begin
    $error("ext_read_q and ext_write_q high together");
    fail_cnt++;
  end

  // done pulse follows the memory answer by one cycle
  a_read_done: assert property (
    @(posedge clk) disable iff (ext_rst_e) read_dn |-> $past(ext_read_dn)
  ) else begin
    $error("read_dn without ext_read_dn the cycle before");
    fail_cnt++;
  end

  a_write_done: assert property (
    @(posedge clk) disable iff (ext_rst_e) write_dn |-> $past(ext_write_dn)
  ) else begin
    $error("write_dn without ext_write_dn the cycle before");
    fail_cnt++;
  end

endmodule

bind cpu_dispatcher cpu_dispatcher_chk u_chk (
  .clk          (clk),
  .ext_rst_e    (ext_rst_e),
  .cpu_q        (cpu_q),
  .ext_read_q   (ext_read_q),
  .ext_write_q  (ext_write_q),
  .ext_read_dn  (ext_read_dn),
  .ext_write_dn (ext_write_dn),
  .read_dn      (read_dn),
  .write_dn     (write_dn)
);

/* tests/cpu_dispatcher_tb.sv */
`timescale 1ns/1ps

`include "disp_cfg.svh"

module cpu_dispatcher_tb;

  import disp_pkg::*;

  localparam int TEST_QTY = 6;
  // longest single wait on the dut, in cycles
  localparam int WAIT_MAX = 20;

  logic     clk;
  logic     ext_rst_e;
  logic     bus_busy;
  logic     dispatcher_q;
  logic     cpu_e;
  cpu_msg_t cpu_msg;
  logic     cpu_q;
  cpu_idx_t cpu_index;
  logic     read_q;
  logic     write_q;
  addr_t    cpu_addr;
  data_t    cpu_wdata;
  logic     read_dn;
  logic     write_dn;
  data_t    cpu_rdata;
  logic     ext_read_q;
  logic     ext_write_q;
  addr_t    ext_mem_addr;
  data_t    ext_mem_wdata;
  data_t    ext_mem_rdata;
  logic     ext_read_dn;
  logic     ext_write_dn;

  // random source for stimulus and memory model
  logic [31:0] lfsr = 32'h1cde_e13f;

  // expected scheduler state
  int m_active;
  int m_idle;
  int m_num;
  bit m_idle_flag;

  // what the memory model last saw and returned
  addr_t mdl_addr;
  data_t mdl_wdata;
  data_t mdl_rdata;

  cpu_dispatcher dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // idle slot first unless it was just given
  task automatic model_grant(output cpu_idx_t idx);
    idx = '0;
    if (m_idle > 0 && !m_idle_flag) begin
      m_idle_flag = 1'b1;
    end else begin
      m_num = m_num + 1;
      if (m_num >= m_active) begin
        m_num = 0;
      end
      idx[`DISP_ACTIVE_BIT] = 1'b1;
      idx[`DISP_ACTIVE_BIT-1:0] = m_num[`DISP_ACTIVE_BIT-1:0];
      m_idle_flag = 1'b0;
    end
  endtask

  task automatic model_msg(input cpu_msg_t msg);
    if (msg == MSG_START && m_idle > 0) begin
      m_idle = m_idle - 1;
      m_active = m_active + 1;
      m_num = (m_num + 1) % 128;
      m_idle_flag = 1'b0;
    end else if (msg == MSG_END && m_active > 0) begin
      m_active = m_active - 1;
      m_idle = m_idle + 1;
    end
  endtask

  // external memory answers each strobe after 0 to 3 cycles
  initial begin
    logic [31:0] delay;
    logic [31:0] rdata;
    logic        is_wr;
    forever begin
      @(negedge clk);
      if (ext_read_q || ext_write_q) begin
        is_wr = ext_write_q;
        rand_bits(2, delay);
        rand_bits(32, rdata);
        mdl_addr = ext_mem_addr;
        mdl_wdata = ext_mem_wdata;
        repeat (delay) begin
          @(negedge clk);
          if (is_wr) begin
            check_val("ext_write_q", ext_write_q, 1'b1);
            check_val("ext_mem_wdata", ext_mem_wdata, mdl_wdata);
          end else begin
            check_val("ext_read_q", ext_read_q, 1'b1);
          end
          check_val("ext_mem_addr", ext_mem_addr, mdl_addr);
        end
        @(posedge clk);
        if (is_wr) begin
          ext_write_dn <= 1'b1;
        end else begin
          mdl_rdata = rdata;
          ext_mem_rdata <= rdata;
          ext_read_dn   <= 1'b1;
        end
        @(posedge clk);
        ext_read_dn  <= 1'b0;
        ext_write_dn <= 1'b0;
      end
    end
  end

  task automatic wait_grant();
    cpu_idx_t exp_idx;
    int       n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cpu_q && n < WAIT_MAX);
    if (!cpu_q) begin
      fail_now("no cpu_q grant came within the wait limit");
    end
    model_grant(exp_idx);
    check_val("cpu_index", cpu_index, exp_idx);
  endtask

  task automatic grant_slot();
    @(posedge clk);
    bus_busy <= 1'b0;
    wait_grant();
  endtask

  // cpu answers its slot with a message and maybe a memory request
  task automatic send_msg(input cpu_msg_t msg, input logic disp_q, input logic rd,
                          input logic wr, output addr_t addr, output data_t wdata);
    @(posedge clk);
    rand_bits(32, addr);
    rand_bits(32, wdata);
    bus_busy     <= 1'b1;
    cpu_e        <= 1'b1;
    cpu_msg      <= msg;
    dispatcher_q <= disp_q;
    read_q       <= rd;
    write_q      <= wr;
    cpu_addr     <= addr;
    cpu_wdata    <= wdata;
    @(posedge clk);
    cpu_e   <= 1'b0;
    cpu_msg <= MSG_NONE;
    read_q  <= 1'b0;
    write_q <= 1'b0;
    model_msg(msg);
    @(negedge clk);
    check_val("cpu_q", cpu_q, 1'b0);
  endtask

  task automatic wait_mem_done(input logic is_wr, input logic no_grant);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    while (!done && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
      if (no_grant) begin
        check_val("cpu_q", cpu_q, 1'b0);
      end
      if (is_wr) begin
        check_val("read_dn", read_dn, 1'b0);
        done = write_dn;
      end else begin
        check_val("write_dn", write_dn, 1'b0);
        done = read_dn;
      end
    end
    if (!done) begin
      fail_now("memory request got no done pulse within the wait limit");
    end
    // strobe drops on the done edge
    check_val("ext_read_q", ext_read_q, 1'b0);
    check_val("ext_write_q", ext_write_q, 1'b0);
    @(negedge clk);
    check_val("read_dn", read_dn, 1'b0);
    check_val("write_dn", write_dn, 1'b0);
    // controller still leaving the memory phase
    if (no_grant) begin
      check_val("cpu_q", cpu_q, 1'b0);
    end
  endtask

  task automatic reset_values();
    @(negedge clk);
    check_val("cpu_q", cpu_q, 1'b0);
    check_val("read_dn", read_dn, 1'b0);
    check_val("write_dn", write_dn, 1'b0);
    check_val("ext_read_q", ext_read_q, 1'b0);
    check_val("ext_write_q", ext_write_q, 1'b0);
    check_val("bridge_busy", dut.bridge_busy, 1'b0);
    check_val("cpu_index", cpu_index, '0);
  endtask

  task automatic idle_alternation();
    addr_t a;
    data_t d;
    for (int i = 0; i < 4; i++) begin
      grant_slot();
      // idle slot, then cpu 0
      check_val("cpu_index", cpu_index, (i % 2 == 0) ? 32'h00 : 32'h80);
      send_msg(MSG_NONE, 1'b1, 1'b0, 1'b0, a, d);
    end
  endtask

  task automatic start_end_messages();
    addr_t a;
    data_t d;
    // fifth start finds no idle cpu
    for (int i = 0; i < 5; i++) begin
      grant_slot();
      send_msg(MSG_START, 1'b1, 1'b0, 1'b0, a, d);
    end
    for (int i = 0; i < 6; i++) begin
      grant_slot();
      send_msg(MSG_NONE, 1'b1, 1'b0, 1'b0, a, d);
    end
    // fifth end finds nothing active
    for (int i = 0; i < 5; i++) begin
      grant_slot();
      send_msg(MSG_END, 1'b1, 1'b0, 1'b0, a, d);
    end
    for (int i = 0; i < 4; i++) begin
      grant_slot();
      send_msg(MSG_NONE, 1'b1, 1'b0, 1'b0, a, d);
    end
  endtask

  task automatic read_forwarding();
    addr_t a;
    data_t d;
    for (int i = 0; i < 4; i++) begin
      grant_slot();
      send_msg(MSG_NONE, 1'b0, 1'b1, 1'b0, a, d);
      wait_mem_done(1'b0, 1'b0);
      check_val("ext_mem_addr", mdl_addr, a);
      check_val("cpu_rdata", cpu_rdata, mdl_rdata);
      @(posedge clk);
      dispatcher_q <= 1'b1;
    end
  endtask

  task automatic write_forwarding();
    addr_t a;
    data_t d;
    for (int i = 0; i < 4; i++) begin
      grant_slot();
      send_msg(MSG_NONE, 1'b0, 1'b0, 1'b1, a, d);
      wait_mem_done(1'b1, 1'b0);
      check_val("ext_mem_addr", mdl_addr, a);
      check_val("ext_mem_wdata", mdl_wdata, d);
      @(posedge clk);
      dispatcher_q <= 1'b1;
    end
  endtask

  task automatic stall_behavior();
    addr_t a;
    data_t d;
    // busy bus blocks every grant
    @(posedge clk);
    bus_busy <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_val("cpu_q", cpu_q, 1'b0);
    end
    grant_slot();
    send_msg(MSG_NONE, 1'b0, 1'b0, 1'b1, a, d);
    // bus free and dispatcher_q high, yet the bridge holds the grant back
    @(posedge clk);
    dispatcher_q <= 1'b1;
    bus_busy     <= 1'b0;
    wait_mem_done(1'b1, 1'b1);
    check_val("ext_mem_wdata", mdl_wdata, d);
    wait_grant();
    send_msg(MSG_NONE, 1'b1, 1'b0, 1'b0, a, d);
  endtask

  initial begin
    repeat (TEST_QTY * 200) @(posedge clk);
    fail_now("timeout, the tests did not finish in the allotted cycles");
  end

  initial begin
    wait (dut.u_chk.fail_cnt != 0);
    fail_now("an assertion in the bound checker failed");
  end

  initial begin
    ext_rst_e     = 1'b1;
    bus_busy      = 1'b1;
    dispatcher_q  = 1'b1;
    cpu_e         = 1'b0;
    cpu_msg       = MSG_NONE;
    read_q        = 1'b0;
    write_q       = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    ext_mem_rdata = '0;
    ext_read_dn   = 1'b0;
    ext_write_dn  = 1'b0;
    m_active      = 0;
    m_idle        = `DISP_CPU_QTY;
    m_num         = 0;
    m_idle_flag   = 1'b0;
    repeat (3) @(posedge clk);
    ext_rst_e <= 1'b0;

    reset_values();
    idle_alternation();
    start_end_messages();
    read_forwarding();
    write_forwarding();
    stall_behavior();

    @(negedge clk);
    if (dut.u_chk.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("%0d assertion failures in the bound checker", dut.u_chk.fail_cnt);
      $display(">>> FAIL");
      $fatal(1, "bound checker reported failures");
    end
  end

endmodule
